/* project.f */
source/wc_pkg.sv
source/wc_region_decode.sv
source/wc_shared_arbiter.sv
source/wc_shared_ram.sv
source/wc_scroll_regs.sv
source/wc_game.sv
tests/wc_game_tb.sv

/* Bender.yml */
package:
  name: wc_game

sources:
  - files:
      - source/wc_pkg.sv
      - source/wc_region_decode.sv
      - source/wc_shared_arbiter.sv
      - source/wc_shared_ram.sv
      - source/wc_scroll_regs.sv
      - source/wc_game.sv
  - target: test
    files:
      - tests/wc_game_tb.sv

/* tests/wc_game_tb.sv */
// random two-port traffic against a reference model; reads of never-written RAM bytes are not compared
module wc_game_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import wc_pkg::*;

    localparam int N_ACCESS = 3000;
    localparam int TIMEOUT  = 4;

    logic       clk;
    logic       rst_n;
    cpu_bus_t   main_bus;
    cpu_bus_t   sub_bus;
    logic       main_wait;
    logic       sub_wait;
    logic [7:0] main_din;
    logic [7:0] sub_din;
    logic [8:0] scrx;
    logic [7:0] scry;

    // reference model, index 0 is the main port and 1 the sub port
    logic [7:0] mem_model [5][2048];
    bit         mem_known [5][2048];
    logic [7:0] exp_din   [2];
    bit         din_known [2];
    logic [8:0] exp_scrx;
    logic [7:0] exp_scry;
    owner_e     last_grant;

    wc_game #(
        .RAM_BANKS ( 5         ),
        .RAM_DEPTH ( 2048      )
    ) dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .main_bus  ( main_bus  ),
        .sub_bus   ( sub_bus   ),
        .main_wait ( main_wait ),
        .sub_wait  ( sub_wait  ),
        .main_din  ( main_din  ),
        .sub_din   ( sub_din   ),
        .scrx      ( scrx      ),
        .scry      ( scry      )
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_wait(input logic exp_main, input logic exp_sub);
        if (main_wait !== exp_main || sub_wait !== exp_sub) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: wait main/sub expected %b/%b got %b/%b",
                                      $time, exp_main, exp_sub, main_wait, sub_wait));
        end
    endtask

    task automatic check_din(input string port, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: %s din expected %h got %h",
                                      $time, port, exp, got));
        end
    endtask

    task automatic check_scroll(input logic [8:0] exp_x, input logic [7:0] exp_y);
        if (scrx !== exp_x || scry !== exp_y) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: scrx/scry expected %h/%h got %h/%h",
                                      $time, exp_x, exp_y, scrx, scry));
        end
    endtask

    task automatic check_outputs();
        if (din_known[0]) begin
            check_din("main", exp_din[0], main_din);
        end
        if (din_known[1]) begin
            check_din("sub", exp_din[1], sub_din);
        end
        check_scroll(exp_scrx, exp_scry);
    endtask

    // shared window index 0..4 from C800 upward, -1 elsewhere
    function automatic int window_of(input logic [15:0] addr);
        if (addr >= 16'hC800 && addr < 16'hF000) begin
            return int'((addr - 16'hC800) >> 11);
        end
        return -1;
    endfunction

    // mostly shared windows, low offsets so that reads hit earlier writes
    function automatic cpu_bus_t random_bus();
        cpu_bus_t    b;
        int          kind;
        logic [10:0] off;
        kind = $urandom % 16;
        off  = ($urandom % 4 != 0) ? 11'($urandom % 16) : 11'($urandom);
        b.cs   = 1'b1;
        b.wr_n = 1'($urandom % 2);
        b.dout = 8'($urandom);
        if (kind < 12) begin
            b.addr = 16'(32'hC800 + ($urandom % 5) * 32'h800 + off);
        end else if (kind < 14) begin
            b.addr = 16'(32'hF000 + (($urandom % 4 != 0) ? ($urandom % 4) : off));
        end else if ($urandom % 2 != 0) begin
            b.addr = 16'($urandom_range(32'hC7FF, 0));
        end else begin
            b.addr = 16'hF800 + 16'(off);
        end
        return b;
    endfunction

    // model effect of one accepted access
    task automatic apply_access(input int p, input cpu_bus_t b);
        int bank;
        int off;
        bank = window_of(b.addr);
        off  = int'(b.addr[10:0]);
        if (bank >= 0) begin
            if (!b.wr_n) begin
                mem_model[bank][off] = b.dout;
                mem_known[bank][off] = 1'b1;
            end else begin
                exp_din[p]   = mem_model[bank][off];
                din_known[p] = mem_known[bank][off];
            end
        end else if (p == 0 && b.addr >= 16'hF000 && b.addr < 16'hF800 && !b.wr_n) begin
            case (off)
                0: exp_scrx[7:0] = b.dout;
                1: exp_scrx[8]   = b.dout[0];
                2: exp_scry      = b.dout;
                default: ;
            endcase
        end else if (b.wr_n) begin
            // unmapped, sub scroll page and scroll reads
            exp_din[p]   = 8'hFF;
            din_known[p] = 1'b1;
        end
    endtask

    // each port issues its next request right after the previous one was accepted
    task automatic run_traffic();
        cpu_bus_t req_q    [2];
        bit       pending  [2];
        int       issued   [2];
        int       stalled  [2];
        logic     exp_wait [2];
        bit       contend;
        for (int p = 0; p < 2; p++) begin
            pending[p] = 1'b0;
            issued[p]  = 0;
            stalled[p] = 0;
        end
        while (pending[0] || pending[1] || issued[0] < N_ACCESS || issued[1] < N_ACCESS) begin
            for (int p = 0; p < 2; p++) begin
                if (!pending[p] && issued[p] < N_ACCESS) begin
                    req_q[p]   = random_bus();
                    pending[p] = 1'b1;
                    stalled[p] = 0;
                    issued[p]++;
                end
            end
            if (stalled[0] >= TIMEOUT || stalled[1] >= TIMEOUT) begin
                stop_with_error($sformatf("ERROR at %0t ns: request not accepted in %0d cycles",
                                          $time, TIMEOUT));
            end
            main_bus    = req_q[0];
            sub_bus     = req_q[1];
            main_bus.cs = pending[0];
            sub_bus.cs  = pending[1];
            #1;
            // stall bound taken from the DUT's own wait lines
            if ((main_wait && stalled[0] > 0) || (sub_wait && stalled[1] > 0)) begin
                stop_with_error($sformatf("ERROR at %0t ns: a port waited more than one cycle",
                                          $time));
            end
            contend     = pending[0] && (window_of(req_q[0].addr) >= 0) &&
                          pending[1] && (window_of(req_q[1].addr) >= 0);
            // the port granted on the last conflict yields
            exp_wait[0] = contend && (last_grant == OWN_MAIN);
            exp_wait[1] = contend && (last_grant == OWN_SUB);
            check_wait(exp_wait[0], exp_wait[1]);
            @(posedge clk);
            for (int p = 0; p < 2; p++) begin
                if (pending[p] && !exp_wait[p]) begin
                    apply_access(p, req_q[p]);
                    pending[p] = 1'b0;
                end else if (pending[p]) begin
                    stalled[p]++;
                end
            end
            if (contend) begin
                last_grant = exp_wait[0] ? OWN_SUB : OWN_MAIN;
            end
            @(negedge clk);
            check_outputs();
        end
    endtask

    initial begin
        void'($urandom(32'hf7b5_f22c));
        clk          = 1'b0;
        rst_n        = 1'b0;
        main_bus     = '0;
        sub_bus      = '0;
        exp_din[0]   = 8'h00;
        exp_din[1]   = 8'h00;
        din_known[0] = 1'b1;
        din_known[1] = 1'b1;
        exp_scrx     = '0;
        exp_scry     = '0;
        last_grant   = OWN_SUB;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_wait(1'b0, 1'b0);
        check_outputs();
        rst_n = 1'b1;
        run_traffic();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* source/wc_game.sv */
// shared-memory top for two CPUs; CPUs hold cs as a level and use the wait line as back-pressure
module wc_game #(
    parameter int RAM_BANKS = 5,
    parameter int RAM_DEPTH = 2048
) (
    input  logic             clk,
    input  logic             rst_n,
    input  wc_pkg::cpu_bus_t main_bus,
    input  wc_pkg::cpu_bus_t sub_bus,
    output logic             main_wait,
    output logic             sub_wait,
    output logic [7:0]       main_din,
    output logic [7:0]       sub_din,
    output logic [8:0]       scrx,
    output logic [7:0]       scry
);
    import wc_pkg::*;

    access_t     main_acc;
    access_t     sub_acc;
    shared_req_t sh_req;
    logic        sh_grant;

    wc_region_decode #(
        .HAS_SCROLL ( 1'b1          )
    ) u_main_dec (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .bus        ( main_bus      ),
        .acc        ( main_acc      )
    );

    // sub CPU has no scroll page
    wc_region_decode #(
        .HAS_SCROLL ( 1'b0          )
    ) u_sub_dec (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .bus        ( sub_bus       ),
        .acc        ( sub_acc       )
    );

    wc_shared_arbiter u_arbiter (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .main_acc   ( main_acc      ),
        .sub_acc    ( sub_acc       ),
        .req        ( sh_req        ),
        .grant      ( sh_grant      ),
        .main_wait  ( main_wait     ),
        .sub_wait   ( sub_wait      )
    );

    wc_shared_ram #(
        .BANKS      ( RAM_BANKS     ),
        .DEPTH      ( RAM_DEPTH     )
    ) u_ram (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .req        ( sh_req        ),
        .grant      ( sh_grant      ),
        .main_acc   ( main_acc      ),
        .sub_acc    ( sub_acc       ),
        .main_wait  ( main_wait     ),
        .sub_wait   ( sub_wait      ),
        .main_din   ( main_din      ),
        .sub_din    ( sub_din       )
    );

    wc_scroll_regs u_scroll (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .acc        ( main_acc      ),
        .scrx       ( scrx          ),
        .scry       ( scry          )
    );

endmodule

/* source/wc_scroll_regs.sv */
// main CPU scroll registers at F000-F002, write only; other offsets in the page are ignored
module wc_scroll_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  wc_pkg::access_t acc,
    output logic [8:0]      scrx,
    output logic [7:0]      scry
);
    import wc_pkg::*;

    logic wr;

    // scroll writes never wait, so any local write here is accepted
    assign wr = acc.is_local && acc.we && (acc.region == REG_SCROLL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scrx <= '0;
            scry <= '0;
        end else if (wr) begin
            case (acc.offset)
                11'd0: begin
                    scrx[7:0] <= acc.wdata;
                end
                11'd1: begin
                    // only the MSB of the horizontal scroll
                    scrx[8] <= acc.wdata[0];
                end
                11'd2: begin
                    scry <= acc.wdata;
                end
                default: ;
            endcase
        end
    end

endmodule

/* source/wc_shared_ram.sv */
// five byte-wide banks behind one shared port; din is loaded at the accepting edge and then held
module wc_shared_ram #(
    parameter int BANKS = 5,
    parameter int DEPTH = 2048
) (
    input  logic                clk,
    input  logic                rst_n,
    input  wc_pkg::shared_req_t req,
    input  logic                grant,
    input  wc_pkg::access_t     main_acc,
    input  wc_pkg::access_t     sub_acc,
    input  logic                main_wait,
    input  logic                sub_wait,
    output logic [7:0]          main_din,
    output logic [7:0]          sub_din
);
    import wc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [7:0] mem [BANKS][DEPTH];
    logic [2:0] bank;
    logic [7:0] rd_data;
    access_t    port_acc  [2];
    logic [7:0] din_q     [2];

    // work RAM is bank 0, scroll VRAM the last one
    assign bank    = 3'(req.acc.region) - 3'd1;
    assign rd_data = (int'(bank) < BANKS) ? mem[bank][req.acc.offset[AW-1:0]] : OPEN_BUS;

    always_ff @(posedge clk) begin
        if (grant && req.acc.we) begin
            mem[bank][req.acc.offset[AW-1:0]] <= req.acc.wdata;
        end
    end

    // ports indexed by owner value
    assign port_acc[OWN_MAIN]  = main_acc;
    assign port_acc[OWN_SUB]   = sub_acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < 2; p++) begin
                din_q[p] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (grant && req.owner == owner_e'(p) && !req.acc.we) begin
                    din_q[p] <= rd_data;
                end else if (port_acc[p].is_local && !port_acc[p].we) begin
                    // unmapped and scroll reads
                    din_q[p] <= OPEN_BUS;
                end
            end
        end
    end

    assign main_din = din_q[OWN_MAIN];
    assign sub_din  = din_q[OWN_SUB];

    // only real windows reach the banks
    a_grant_region : assert property (
        @(posedge clk) disable iff (!rst_n)
        grant |-> !(req.acc.region inside {REG_NONE, REG_SCROLL})
    ) else $error("shared bus granted to a non-RAM region");

    // a port that asks and does not wait must own the bus
    a_owner_matches : assert property (
        @(posedge clk) disable iff (!rst_n)
        (!main_acc.valid || main_wait || req.owner == OWN_MAIN) &&
        (!sub_acc.valid || sub_wait || req.owner == OWN_SUB)
    ) else $error("access accepted without owning the bus");

endmodule

/* source/wc_shared_arbiter.sv */
// one shared-bus grant per cycle with alternating priority; main wins the first conflict after reset
module wc_shared_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  wc_pkg::access_t     main_acc,
    input  wc_pkg::access_t     sub_acc,
    output wc_pkg::shared_req_t req,
    output logic                grant,
    output logic                main_wait,
    output logic                sub_wait
);
    import wc_pkg::*;

    owner_e last_q;
    owner_e winner;
    logic   main_req;
    logic   sub_req;
    logic   contend;

    assign main_req = main_acc.valid;
    assign sub_req  = sub_acc.valid;
    assign contend  = main_req && sub_req;

    // the port not granted on the last conflict goes first
    always_comb begin
        if (contend) begin
            winner = (last_q == OWN_SUB) ? OWN_MAIN : OWN_SUB;
        end else if (main_req) begin
            winner = OWN_MAIN;
        end else begin
            winner = OWN_SUB;
        end
    end

    assign grant     = main_req || sub_req;
    assign main_wait = contend && (winner == OWN_SUB);
    assign sub_wait  = contend && (winner == OWN_MAIN);

    // forward the winning access to the RAM
    always_comb begin
        req.owner = winner;
        if (winner == OWN_MAIN) begin
            req.acc = main_acc;
        end else begin
            req.acc = sub_acc;
        end
    end

    // only conflicts move the priority
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= OWN_SUB;
        end else if (contend) begin
            last_q <= winner;
        end
    end

    a_one_wait : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(main_wait && sub_wait)
    ) else $error("both ports waiting");

    // local and idle ports are never stalled
    a_wait_needs_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        (!main_wait || main_acc.valid) && (!sub_wait || sub_acc.valid)
    ) else $error("wait raised on a port without a shared request");

endmodule

/* source/wc_region_decode.sv */
// combinational address decode of one CPU port; the scroll page only exists when HAS_SCROLL is 1
module wc_region_decode #(
    parameter bit HAS_SCROLL = 1'b0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  wc_pkg::cpu_bus_t bus,
    output wc_pkg::access_t  acc
);
    import wc_pkg::*;

    region_e region;
    logic    shared_hit;

    // window match on the upper five address bits
    always_comb begin
        case (bus.addr[15:11])
            WIN_WORK[7:3]:   region = REG_WORK;
            WIN_FIX[7:3]:    region = REG_FIX;
            WIN_PAL[7:3]:    region = REG_PAL;
            WIN_OBJ[7:3]:    region = REG_OBJ;
            WIN_VRAM[7:3]:   region = REG_VRAM;
            WIN_SCROLL[7:3]: region = HAS_SCROLL ? REG_SCROLL : REG_NONE;
            default:         region = REG_NONE;
        endcase
    end

    assign shared_hit = (region != REG_NONE) && (region != REG_SCROLL);

    always_comb begin
        acc.valid    = bus.cs && shared_hit;
        // unmapped and scroll accesses finish without arbitration
        acc.is_local = bus.cs && !shared_hit;
        acc.region   = region;
        acc.offset   = bus.addr[10:0];
        acc.we       = bus.cs && !bus.wr_n;
        acc.wdata    = bus.dout;
    end

    // a request goes either to the shared bus or completes locally
    a_valid_or_local : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(acc.valid && acc.is_local)
    ) else $error("decoded access is both shared and local");

endmodule

/* source/wc_pkg.sv */
// shared types for the two-CPU memory subsystem; windows are 2 KiB and keyed on addr[15:11]
package wc_pkg;

    // which window a CPU access falls in
    typedef enum logic [2:0] {
        REG_NONE   = 3'd0,
        REG_WORK   = 3'd1,
        REG_FIX    = 3'd2,
        REG_PAL    = 3'd3,
        REG_OBJ    = 3'd4,
        REG_VRAM   = 3'd5,
        REG_SCROLL = 3'd6
    } region_e;

    // port that owns the shared bus this cycle
    typedef enum logic {
        OWN_MAIN = 1'b0,
        OWN_SUB  = 1'b1
    } owner_e;

    // raw CPU request, held as a level while the wait line is high
    typedef struct packed {
        logic        cs;
        logic        wr_n;
        logic [15:0] addr;
        logic [7:0]  dout;
    } cpu_bus_t;

    // decoded access
    // is_local marks accesses that complete without the shared bus
    typedef struct packed {
        logic        valid;
        logic        is_local;
        region_e     region;
        logic [10:0] offset;
        logic        we;
        logic [7:0]  wdata;
    } access_t;

    // access granted to the shared RAM, tagged with its owner
    typedef struct packed {
        owner_e  owner;
        access_t acc;
    } shared_req_t;

    // window bases, only bits 7:3 are compared against addr[15:11]
    localparam logic [7:0] WIN_WORK   = 8'hC8;
    localparam logic [7:0] WIN_FIX    = 8'hD0;
    localparam logic [7:0] WIN_PAL    = 8'hD8;
    localparam logic [7:0] WIN_OBJ    = 8'hE0;
    localparam logic [7:0] WIN_VRAM   = 8'hE8;
    localparam logic [7:0] WIN_SCROLL = 8'hF0;

    // unmapped reads float high
    localparam logic [7:0] OPEN_BUS = 8'hFF;

endpackage
